//--- design/id_pkg.sv
package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [45:0] inst_hit_t;

    // bit order matches the execute stage decoders
    typedef logic [11:0] alu_op_t;
    typedef logic [7:0]  branch_op_t;
    typedef logic [5:0]  mem_op_t;
    typedef logic [3:0]  mul_div_op_t;
    typedef logic [1:0]  src_sel_t;
    typedef logic [4:0]  imm_fmt_t;

    localparam reg_idx_t LINK_REG = 5'd1;

    // immediate format bits
    localparam int F_SI20   = 0;
    localparam int F_I12    = 1;
    localparam int F_OFFS16 = 2;
    localparam int F_OFFS26 = 3;
    localparam int F_UI5    = 4;

    // one hit bit per decoded instruction
    localparam int I_ADD       = 0;
    localparam int I_SUB       = 1;
    localparam int I_SLT       = 2;
    localparam int I_SLTU      = 3;
    localparam int I_NOR       = 4;
    localparam int I_AND       = 5;
    localparam int I_OR        = 6;
    localparam int I_XOR       = 7;
    localparam int I_SLL       = 8;
    localparam int I_SRL       = 9;
    localparam int I_SRA       = 10;
    localparam int I_SLLI      = 11;
    localparam int I_SRLI      = 12;
    localparam int I_SRAI      = 13;
    localparam int I_SLTI      = 14;
    localparam int I_SLTUI     = 15;
    localparam int I_ADDI      = 16;
    localparam int I_ANDI      = 17;
    localparam int I_ORI       = 18;
    localparam int I_XORI      = 19;
    localparam int I_LU12I     = 20;
    localparam int I_PCADDU12I = 21;
    localparam int I_MUL       = 22;
    localparam int I_MULH      = 23;
    localparam int I_MULH_U    = 24;
    localparam int I_DIV       = 25;
    localparam int I_MOD       = 26;
    localparam int I_DIV_WU    = 27;
    localparam int I_MOD_WU    = 28;
    localparam int I_LD_B      = 29;
    localparam int I_LD_H      = 30;
    localparam int I_LD_W      = 31;
    localparam int I_LD_BU     = 32;
    localparam int I_LD_HU     = 33;
    localparam int I_ST_B      = 34;
    localparam int I_ST_H      = 35;
    localparam int I_ST_W      = 36;
    localparam int I_B         = 37;
    localparam int I_BL        = 38;
    localparam int I_BEQ       = 39;
    localparam int I_BNE       = 40;
    localparam int I_BLT       = 41;
    localparam int I_BGE       = 42;
    localparam int I_BLTU      = 43;
    localparam int I_BGEU      = 44;
    localparam int I_JIRL      = 45;

    typedef struct packed {
        alu_op_t     alu_op;
        mul_div_op_t mul_div_op;
        branch_op_t  branch_op;
        mem_op_t     mem_op;
        src_sel_t    src1_sel;
        src_sel_t    src2_sel;
        logic        is_sign;
        reg_idx_t    reg_index1;
        reg_idx_t    reg_index2;
        logic        wreg_en;
        reg_idx_t    wreg_index;
        logic        inst_valid;
        word_t       pc;
        word_t       inst;
        word_t       src1;
        word_t       src2;
        word_t       imm;
    } ctrl_t;

    // instruction currently in execute
    typedef struct packed {
        logic     valid;
        logic     is_load;
        reg_idx_t dest;
    } ex_load_t;

endpackage

//--- design/inst_decoder.sv
module inst_decoder import id_pkg::*; (
    input  word_t     inst,
    output inst_hit_t hits
);

    logic [5:0] op_31_26;
    logic [3:0] op_25_22;
    logic [1:0] op_21_20;
    logic [4:0] op_19_15;
    logic       grp_3r;
    logic       grp_div;
    logic       grp_shift;
    logic       grp_imm;
    logic       grp_mem;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    // opcode groups sharing the upper fields
    assign grp_imm   = (op_31_26 == 6'h00);
    assign grp_3r    = grp_imm & (op_25_22 == 4'h0) & (op_21_20 == 2'h1);
    assign grp_div   = grp_imm & (op_25_22 == 4'h0) & (op_21_20 == 2'h2);
    assign grp_shift = grp_imm & (op_25_22 == 4'h1) & (op_21_20 == 2'h0);
    assign grp_mem   = (op_31_26 == 6'h0a);

    always_comb begin
        hits = '0;

        // three-register forms
        hits[I_ADD]    = grp_3r & (op_19_15 == 5'h00);
        hits[I_SUB]    = grp_3r & (op_19_15 == 5'h02);
        hits[I_SLT]    = grp_3r & (op_19_15 == 5'h04);
        hits[I_SLTU]   = grp_3r & (op_19_15 == 5'h05);
        hits[I_NOR]    = grp_3r & (op_19_15 == 5'h08);
        hits[I_AND]    = grp_3r & (op_19_15 == 5'h09);
        hits[I_OR]     = grp_3r & (op_19_15 == 5'h0a);
        hits[I_XOR]    = grp_3r & (op_19_15 == 5'h0b);
        hits[I_SLL]    = grp_3r & (op_19_15 == 5'h0e);
        hits[I_SRL]    = grp_3r & (op_19_15 == 5'h0f);
        hits[I_SRA]    = grp_3r & (op_19_15 == 5'h10);
        hits[I_MUL]    = grp_3r & (op_19_15 == 5'h18);
        hits[I_MULH]   = grp_3r & (op_19_15 == 5'h19);
        hits[I_MULH_U] = grp_3r & (op_19_15 == 5'h1a);

        hits[I_DIV]    = grp_div & (op_19_15 == 5'h00);
        hits[I_MOD]    = grp_div & (op_19_15 == 5'h01);
        hits[I_DIV_WU] = grp_div & (op_19_15 == 5'h02);
        hits[I_MOD_WU] = grp_div & (op_19_15 == 5'h03);

        // shift amount sits in rk, bit 15 is part of the opcode
        hits[I_SLLI] = grp_shift & (op_19_15 == 5'h01);
        hits[I_SRLI] = grp_shift & (op_19_15 == 5'h09);
        hits[I_SRAI] = grp_shift & (op_19_15 == 5'h11);

        // 12-bit immediate forms
        hits[I_SLTI]  = grp_imm & (op_25_22 == 4'h8);
        hits[I_SLTUI] = grp_imm & (op_25_22 == 4'h9);
        hits[I_ADDI]  = grp_imm & (op_25_22 == 4'ha);
        hits[I_ANDI]  = grp_imm & (op_25_22 == 4'hd);
        hits[I_ORI]   = grp_imm & (op_25_22 == 4'he);
        hits[I_XORI]  = grp_imm & (op_25_22 == 4'hf);

        // 20-bit immediate forms
        hits[I_LU12I]     = (op_31_26 == 6'h05) & ~inst[25];
        hits[I_PCADDU12I] = (op_31_26 == 6'h07) & ~inst[25];

        hits[I_LD_B]  = grp_mem & (op_25_22 == 4'h0);
        hits[I_LD_H]  = grp_mem & (op_25_22 == 4'h1);
        hits[I_LD_W]  = grp_mem & (op_25_22 == 4'h2);
        hits[I_ST_B]  = grp_mem & (op_25_22 == 4'h4);
        hits[I_ST_H]  = grp_mem & (op_25_22 == 4'h5);
        hits[I_ST_W]  = grp_mem & (op_25_22 == 4'h6);
        hits[I_LD_BU] = grp_mem & (op_25_22 == 4'h8);
        hits[I_LD_HU] = grp_mem & (op_25_22 == 4'h9);

        // branches only need the top field
        hits[I_JIRL] = (op_31_26 == 6'h13);
        hits[I_B]    = (op_31_26 == 6'h14);
        hits[I_BL]   = (op_31_26 == 6'h15);
        hits[I_BEQ]  = (op_31_26 == 6'h16);
        hits[I_BNE]  = (op_31_26 == 6'h17);
        hits[I_BLT]  = (op_31_26 == 6'h18);
        hits[I_BGE]  = (op_31_26 == 6'h19);
        hits[I_BLTU] = (op_31_26 == 6'h1a);
        hits[I_BGEU] = (op_31_26 == 6'h1b);
    end

    // encodings must not overlap
    hits_onehot: assert final ($onehot0(hits))
        else $error("inst_decoder: several hits for inst %h", inst);

endmodule

//--- design/ctrl_gen.sv
module ctrl_gen import id_pkg::*; (
    input  inst_hit_t hits,
    input  word_t     inst,
    output ctrl_t     ctrl_part,
    output imm_fmt_t  imm_fmt,
    output logic      sign_ext
);

    logic     is_load;
    logic     is_store;
    logic     is_cond_br;
    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    assign is_load = hits[I_LD_B] | hits[I_LD_H] | hits[I_LD_W]
                   | hits[I_LD_BU] | hits[I_LD_HU];
    assign is_store = hits[I_ST_B] | hits[I_ST_H] | hits[I_ST_W];
    assign is_cond_br = hits[I_BEQ] | hits[I_BNE] | hits[I_BLT] | hits[I_BGE]
                      | hits[I_BLTU] | hits[I_BGEU];

    always_comb begin
        ctrl_part = '0;

        // add also serves address and link computation
        ctrl_part.alu_op[0] = hits[I_ADD] | hits[I_ADDI] | hits[I_PCADDU12I] | hits[I_JIRL]
                            | hits[I_B] | hits[I_BL] | is_cond_br | is_load | is_store;
        ctrl_part.alu_op[1]  = hits[I_LU12I];
        ctrl_part.alu_op[2]  = hits[I_OR] | hits[I_ORI];
        ctrl_part.alu_op[3]  = hits[I_SUB];
        ctrl_part.alu_op[4]  = hits[I_XOR] | hits[I_XORI];
        ctrl_part.alu_op[5]  = hits[I_SRA] | hits[I_SRAI];
        ctrl_part.alu_op[6]  = hits[I_AND] | hits[I_ANDI];
        ctrl_part.alu_op[7]  = hits[I_SLL] | hits[I_SLLI];
        ctrl_part.alu_op[8]  = hits[I_SRL] | hits[I_SRLI];
        ctrl_part.alu_op[9]  = hits[I_SLTU] | hits[I_SLTUI];
        ctrl_part.alu_op[10] = hits[I_NOR];
        ctrl_part.alu_op[11] = hits[I_SLT] | hits[I_SLTI];

        ctrl_part.mul_div_op[0] = hits[I_MUL];
        ctrl_part.mul_div_op[1] = hits[I_MOD] | hits[I_MOD_WU];
        ctrl_part.mul_div_op[2] = hits[I_MULH] | hits[I_MULH_U];
        ctrl_part.mul_div_op[3] = hits[I_DIV] | hits[I_DIV_WU];

        ctrl_part.branch_op = {hits[I_BLTU], hits[I_BNE], hits[I_BLT], hits[I_BGEU],
                               hits[I_BEQ], hits[I_BGE], hits[I_B] | hits[I_BL],
                               hits[I_JIRL]};

        // access, unsigned, store, word, half, byte
        ctrl_part.mem_op[0] = is_load | is_store;
        ctrl_part.mem_op[1] = hits[I_LD_BU] | hits[I_LD_HU];
        ctrl_part.mem_op[2] = is_store;
        ctrl_part.mem_op[3] = hits[I_LD_W] | hits[I_ST_W];
        ctrl_part.mem_op[4] = hits[I_LD_H] | hits[I_LD_HU] | hits[I_ST_H];
        ctrl_part.mem_op[5] = hits[I_LD_B] | hits[I_LD_BU] | hits[I_ST_B];

        // bit 0 selects the immediate, bit 1 the pc
        ctrl_part.src1_sel[0] = hits[I_LU12I] | hits[I_PCADDU12I];
        ctrl_part.src1_sel[1] = hits[I_B] | hits[I_BL] | is_cond_br;
        ctrl_part.src2_sel[0] = hits[I_ADDI] | hits[I_ANDI] | hits[I_ORI] | hits[I_XORI]
                              | hits[I_SLTI] | hits[I_SLTUI] | hits[I_SLLI] | hits[I_SRLI]
                              | hits[I_SRAI] | hits[I_JIRL] | hits[I_B] | hits[I_BL]
                              | is_cond_br | is_load | is_store;
        ctrl_part.src2_sel[1] = hits[I_PCADDU12I];

        ctrl_part.is_sign = hits[I_MUL] | hits[I_MOD] | hits[I_MULH] | hits[I_DIV];

        ctrl_part.reg_index1 = rj;
        ctrl_part.reg_index2 = (is_store | is_cond_br) ? rd : rk;
        ctrl_part.wreg_index = hits[I_BL] ? LINK_REG : rd;
        ctrl_part.wreg_en    = (|hits) & ~is_store & ~is_cond_br & ~hits[I_B];
        ctrl_part.inst_valid = |hits;
    end

    assign imm_fmt[F_SI20]   = hits[I_LU12I] | hits[I_PCADDU12I];
    assign imm_fmt[F_I12]    = hits[I_ADDI] | hits[I_ANDI] | hits[I_ORI] | hits[I_XORI]
                             | hits[I_SLTI] | hits[I_SLTUI] | is_load | is_store;
    assign imm_fmt[F_OFFS16] = hits[I_JIRL] | is_cond_br;
    assign imm_fmt[F_OFFS26] = hits[I_B] | hits[I_BL];
    assign imm_fmt[F_UI5]    = hits[I_SLLI] | hits[I_SRLI] | hits[I_SRAI];

    // logical immediates stay zero-extended
    assign sign_ext = hits[I_ADDI] | hits[I_SLTI] | hits[I_SLTUI] | hits[I_JIRL]
                    | is_cond_br | is_load | is_store;

endmodule

//--- design/imm_gen.sv
module imm_gen import id_pkg::*; (
    input  word_t    inst,
    input  imm_fmt_t imm_fmt,
    input  logic     sign_ext,
    output word_t    imm
);

    word_t imm_si20;
    word_t imm_i12;
    word_t imm_offs16;
    word_t imm_offs26;
    word_t imm_ui5;

    assign imm_si20 = {inst[24:5], 12'h000};

    assign imm_i12 = sign_ext ? {{20{inst[21]}}, inst[21:10]} : {20'h0, inst[21:10]};

    // branch offsets count words
    assign imm_offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};

    // high part of offs26 lives in the low bits
    assign imm_offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    assign imm_ui5 = {27'h0, inst[14:10]};

    always_comb begin
        imm = '0;
        case (imm_fmt)
            5'b00001: imm = imm_si20;
            5'b00010: imm = imm_i12;
            5'b00100: imm = imm_offs16;
            5'b01000: imm = imm_offs26;
            5'b10000: imm = imm_ui5;
            default:  imm = '0;
        endcase
    end

    // ctrl_gen must never ask for two formats at once
    fmt_onehot: assert final ($onehot0(imm_fmt))
        else $error("imm_gen: imm_fmt %b not one-hot", imm_fmt);

endmodule

//--- design/id_pipe_reg.sv
module id_pipe_reg import id_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  ctrl_t    ctrl_in,
    input  ex_load_t ex_load,
    input  logic     left_valid,
    input  logic     right_ready,
    input  logic     fire,
    input  logic     flush,
    output logic     left_ready,
    output logic     right_valid,
    output ctrl_t    ctrl
);

    logic stall;
    logic accept;
    logic valid;
    logic valid_nxt;

    // load in execute writes a register we are about to read
    assign stall = ex_load.valid & ex_load.is_load
                 & ((ex_load.dest == ctrl_in.reg_index1)
                 | (ex_load.dest == ctrl_in.reg_index2));

    assign left_ready = right_ready & ~stall;
    assign accept     = left_valid & right_ready & ~stall;

    // fire drops the old entry, accept sets a new one, flush wins
    assign valid_nxt = ((fire ? 1'b0 : valid) | accept) & ~flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else if (accept) begin
            ctrl <= ctrl_in;
        end
    end

    assign right_valid = valid;

    flush_clears_valid: assert property (
        @(posedge clk) disable iff (!rst_n) flush |=> !right_valid
    ) else $error("id_pipe_reg: right_valid high after flush");

    // back-pressure must freeze the bundle seen by execute
    hold_under_backpressure: assert property (
        @(posedge clk) disable iff (!rst_n) !right_ready |=> $stable(ctrl)
    ) else $error("id_pipe_reg: ctrl changed while right_ready low");

endmodule

//--- design/id_stage.sv
module id_stage import id_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    inst,
    input  word_t    pc,
    input  word_t    reg_data1,
    input  word_t    reg_data2,
    input  ex_load_t ex_load,
    input  logic     left_valid,
    input  logic     right_ready,
    input  logic     fire,
    input  logic     flush,
    output reg_idx_t reg_index1,
    output reg_idx_t reg_index2,
    output logic     left_ready,
    output logic     right_valid,
    output ctrl_t    ctrl
);

    inst_hit_t hits;
    ctrl_t     ctrl_part;
    ctrl_t     ctrl_in;
    imm_fmt_t  imm_fmt;
    logic      sign_ext;
    word_t     imm;

    inst_decoder inst_decoder_i (
        .inst (inst),
        .hits (hits)
    );

    ctrl_gen ctrl_gen_i (
        .hits      (hits),
        .inst      (inst),
        .ctrl_part (ctrl_part),
        .imm_fmt   (imm_fmt),
        .sign_ext  (sign_ext)
    );

    imm_gen imm_gen_i (
        .inst     (inst),
        .imm_fmt  (imm_fmt),
        .sign_ext (sign_ext),
        .imm      (imm)
    );

    // decoded fields plus the payload words
    always_comb begin
        ctrl_in      = ctrl_part;
        ctrl_in.pc   = pc;
        ctrl_in.inst = inst;
        ctrl_in.src1 = reg_data1;
        ctrl_in.src2 = reg_data2;
        ctrl_in.imm  = imm;
    end

    // register file read ports
    assign reg_index1 = ctrl_part.reg_index1;
    assign reg_index2 = ctrl_part.reg_index2;

    id_pipe_reg id_pipe_reg_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl_in     (ctrl_in),
        .ex_load     (ex_load),
        .left_valid  (left_valid),
        .right_ready (right_ready),
        .fire        (fire),
        .flush       (flush),
        .left_ready  (left_ready),
        .right_valid (right_valid),
        .ctrl        (ctrl)
    );

endmodule

//--- bench/tb_id_stage.sv
module tb_id_stage import id_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_REC       = 47;
    localparam int REC_W       = 15;
    localparam int CYCLE_LIMIT = 20 * N_REC + 100;

    logic     clk;
    logic     rst_n;
    word_t    inst;
    word_t    pc;
    word_t    reg_data1;
    word_t    reg_data2;
    ex_load_t ex_load;
    logic     left_valid;
    logic     right_ready;
    logic     fire;
    logic     flush;
    reg_idx_t reg_index1;
    reg_idx_t reg_index2;
    logic     left_ready;
    logic     right_valid;
    ctrl_t    ctrl;

    // inst pc reg_data1 reg_data2 ex_load, then the expected fields
    word_t       pat [N_REC * REC_W];
    logic [31:0] rng_state;
    int          err_count;
    int          cycle_count;

    id_stage id_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst        (inst),
        .pc          (pc),
        .reg_data1   (reg_data1),
        .reg_data2   (reg_data2),
        .ex_load     (ex_load),
        .left_valid  (left_valid),
        .right_ready (right_ready),
        .fire        (fire),
        .flush       (flush),
        .reg_index1  (reg_index1),
        .reg_index2  (reg_index2),
        .left_ready  (left_ready),
        .right_valid (right_valid),
        .ctrl        (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ready three times out of four
    task automatic draw_ready();
        rng_state   = xorshift32(rng_state);
        right_ready = (rng_state[1:0] != 2'b00);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_bundle(input int base);
        expect_eq("ctrl.alu_op", 32'(ctrl.alu_op), pat[base + 5]);
        expect_eq("ctrl.branch_op", 32'(ctrl.branch_op), pat[base + 6]);
        expect_eq("ctrl.mem_op", 32'(ctrl.mem_op), pat[base + 7]);
        expect_eq("ctrl.mul_div_op", 32'(ctrl.mul_div_op), pat[base + 8]);
        expect_eq("ctrl.imm", ctrl.imm, pat[base + 9]);
        expect_eq("ctrl.wreg_en", 32'(ctrl.wreg_en), pat[base + 10]);
        expect_eq("ctrl.wreg_index", 32'(ctrl.wreg_index), pat[base + 11]);
        expect_eq("ctrl.reg_index2", 32'(ctrl.reg_index2), pat[base + 12]);
        expect_eq("ctrl.inst_valid", 32'(ctrl.inst_valid), pat[base + 13]);
        // rj field of the word
        expect_eq("ctrl.reg_index1", 32'(ctrl.reg_index1), 32'(pat[base][9:5]));
        expect_eq("ctrl.inst", ctrl.inst, pat[base]);
        expect_eq("ctrl.pc", ctrl.pc, pat[base + 1]);
        expect_eq("ctrl.src1", ctrl.src1, pat[base + 2]);
        expect_eq("ctrl.src2", ctrl.src2, pat[base + 3]);
    endtask

    // present one record, wait for accept, check, hold, then fire
    task automatic run_record(input int idx);
        int    base;
        int    stall_cycles;
        int    hold_cycles;
        logic  stall_on;
        logic  accepted;
        ctrl_t saved;
        base         = idx * REC_W;
        stall_cycles = 0;
        accepted     = 1'b0;
        stall_on     = pat[base + 14][0];
        inst         = pat[base];
        pc           = pat[base + 1];
        reg_data1    = pat[base + 2];
        reg_data2    = pat[base + 3];
        ex_load      = ex_load_t'(pat[base + 4][6:0]);
        left_valid   = 1'b1;
        while (!accepted) begin
            if (stall_on && stall_cycles >= 3) begin
                ex_load  = '0;
                stall_on = 1'b0;
            end
            draw_ready();
            @(negedge clk);
            expect_eq("left_ready", 32'(left_ready), 32'(right_ready & ~stall_on));
            expect_eq("right_valid", 32'(right_valid), 32'h0);
            expect_eq("reg_index1", 32'(reg_index1), 32'(pat[base][9:5]));
            expect_eq("reg_index2", 32'(reg_index2), pat[base + 12]);
            accepted = left_ready;
            if (stall_on) begin
                stall_cycles++;
            end
            @(posedge clk);
            #2;
        end
        left_valid = 1'b0;
        ex_load    = '0;
        expect_eq("right_valid", 32'(right_valid), 32'h1);
        check_bundle(base);

        // back-pressure from execute while fetch offers new operands
        rng_state   = xorshift32(rng_state);
        hold_cycles = int'(rng_state[3:2]) % 3;
        saved       = ctrl;
        right_ready = 1'b0;
        left_valid  = 1'b1;
        reg_data1   = ~pat[base + 2];
        repeat (hold_cycles) begin
            @(negedge clk);
            expect_eq("left_ready", 32'(left_ready), 32'h0);
            @(posedge clk);
            #2;
            expect_eq("right_valid", 32'(right_valid), 32'h1);
            assert (ctrl === saved) else begin
                $display("mismatch ctrl: got %h expected %h", ctrl, saved);
                err_count++;
            end
        end

        left_valid  = 1'b0;
        right_ready = 1'b1;
        fire        = 1'b1;
        @(posedge clk);
        #2;
        fire = 1'b0;
        expect_eq("right_valid", 32'(right_valid), 32'h0);
    endtask

    task automatic flush_after_accept();
        inst        = pat[0];
        pc          = pat[1];
        reg_data1   = pat[2];
        reg_data2   = pat[3];
        ex_load     = '0;
        left_valid  = 1'b1;
        right_ready = 1'b1;
        @(posedge clk);
        #2;
        left_valid = 1'b0;
        expect_eq("right_valid", 32'(right_valid), 32'h1);
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        expect_eq("right_valid", 32'(right_valid), 32'h0);
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: stage did not finish within %0d cycles", CYCLE_LIMIT);
        $display("errors: %0d mismatches, 1 timeout", err_count);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        err_count   = 0;
        rng_state   = 32'd17;
        rst_n       = 1'b0;
        inst        = '0;
        pc          = '0;
        reg_data1   = '0;
        reg_data2   = '0;
        ex_load     = '0;
        left_valid  = 1'b0;
        right_ready = 1'b1;
        fire        = 1'b0;
        flush       = 1'b0;
        $readmemh("bench/id_patterns.mem", pat);

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        expect_eq("right_valid", 32'(right_valid), 32'h0);
        expect_eq("left_ready", 32'(left_ready), 32'h1);
        assert (ctrl === '0) else begin
            $display("mismatch ctrl: got %h expected 0 after reset", ctrl);
            err_count++;
        end
        @(posedge clk);
        #2;

        for (int i = 0; i < N_REC; i++) begin
            run_record(i);
        end
        flush_after_accept();

        $display("errors: %0d mismatches, 0 timeouts", err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/id_patterns.mem
// inst pc reg_data1 reg_data2 ex_load | alu_op branch_op mem_op mul_div_op imm
// wreg_en wreg_index reg_index2 inst_valid stall
00101483 1c000000 a0000001 b0000001 00 001 00 00 0 00000000 1 03 05 1 0
00111483 1c000004 a0000002 b0000002 00 008 00 00 0 00000000 1 03 05 1 0
00129483 1c000008 a0000003 b0000003 00 200 00 00 0 00000000 1 03 05 1 0
00141483 1c00000c a0000004 b0000004 00 400 00 00 0 00000000 1 03 05 1 0
00149483 1c000010 a0000005 b0000005 00 040 00 00 0 00000000 1 03 05 1 0
00151483 1c000014 a0000006 b0000006 00 004 00 00 0 00000000 1 03 05 1 0
00181483 1c000018 a0000007 b0000007 00 020 00 00 0 00000000 1 03 05 1 0
00409483 1c00001c a0000008 b0000008 00 080 00 00 0 00000005 1 03 05 1 0
00449483 1c000020 a0000009 b0000009 00 100 00 00 0 00000005 1 03 05 1 0
00489483 1c000024 a000000a b000000a 00 020 00 00 0 00000005 1 03 05 1 0
02200083 1c000028 a000000b b000000b 00 800 00 00 0 fffff800 1 03 00 1 0
027ffc83 1c00002c a000000c b000000c 00 200 00 00 0 ffffffff 1 03 1f 1 0
02a00483 1c000030 a000000d b000000d 00 001 00 00 0 fffff801 1 03 01 1 0
03600083 1c000034 a000000e b000000e 00 040 00 00 0 00000800 1 03 00 1 0
03bffc83 1c000038 a000000f b000000f 00 004 00 00 0 00000fff 1 03 1f 1 0
03e96883 1c00003c a0000010 b0000010 00 010 00 00 0 00000a5a 1 03 1a 1 0
142468a3 1c000040 a0000011 b0000011 00 002 00 00 0 12345000 1 03 1a 1 0
1dffffe3 1c000044 a0000012 b0000012 00 001 00 00 0 fffff000 1 03 1f 1 0
001c1483 1c000048 a0000013 b0000013 00 000 00 00 1 00000000 1 03 05 1 0
001c9483 1c00004c a0000014 b0000014 00 000 00 00 4 00000000 1 03 05 1 0
001d1483 1c000050 a0000015 b0000015 00 000 00 00 4 00000000 1 03 05 1 0
00201483 1c000054 a0000016 b0000016 00 000 00 00 8 00000000 1 03 05 1 0
00209483 1c000058 a0000017 b0000017 00 000 00 00 2 00000000 1 03 05 1 0
00211483 1c00005c a0000018 b0000018 00 000 00 00 8 00000000 1 03 05 1 0
00219483 1c000060 a0000019 b0000019 00 000 00 00 2 00000000 1 03 05 1 0
28001083 1c000064 a000001a b000001a 00 001 00 21 0 00000004 1 03 04 1 0
28401083 1c000068 a000001b b000001b 00 001 00 11 0 00000004 1 03 04 1 0
28bff083 1c00006c a000001c b000001c 00 001 00 09 0 fffffffc 1 03 1c 1 0
2a001083 1c000070 a000001d b000001d 00 001 00 23 0 00000004 1 03 04 1 0
2a401083 1c000074 a000001e b000001e 00 001 00 13 0 00000004 1 03 04 1 0
29001083 1c000078 a000001f b000001f 00 001 00 25 0 00000004 0 03 03 1 0
29401083 1c00007c a0000020 b0000020 00 001 00 15 0 00000004 0 03 03 1 0
29801083 1c000080 a0000021 b0000021 00 001 00 0d 0 00000004 0 03 03 1 0
58004083 1c000084 a0000022 b0000022 00 001 08 00 0 00000040 0 03 03 1 0
5ffffc83 1c000088 a0000023 b0000023 00 001 40 00 0 fffffffc 0 03 03 1 0
62000083 1c00008c a0000024 b0000024 00 001 20 00 0 fffe0000 0 03 03 1 0
64000483 1c000090 a0000025 b0000025 00 001 04 00 0 00000004 0 03 03 1 0
68004083 1c000094 a0000026 b0000026 00 001 80 00 0 00000040 0 03 03 1 0
6c004083 1c000098 a0000027 b0000027 00 001 10 00 0 00000040 0 03 03 1 0
4c004083 1c00009c a0000028 b0000028 00 001 01 00 0 00000040 1 03 10 1 0
53fffbff 1c0000a0 a0000029 b0000029 00 001 02 00 0 fffffff8 0 1f 1e 1 0
54040000 1c0000a4 a000002a b000002a 00 001 02 00 0 00000400 1 01 00 1 0
04000003 1c0000a8 a000002b b000002b 00 000 00 00 0 00000000 0 03 00 0 0
06482800 1c0000ac a000002c b000002c 00 000 00 00 0 00000000 0 00 0a 0 0
00101483 1c0000b0 a000002d b000002d 65 001 00 00 0 00000000 1 03 05 1 1
29801083 1c0000b4 a000002e b000002e 63 001 00 0d 0 00000004 0 03 03 1 1
00101483 1c0000b8 a000002f b000002f 45 001 00 00 0 00000000 1 03 05 1 0

//--- filelist.f
design/id_pkg.sv
design/inst_decoder.sv
design/ctrl_gen.sv
design/imm_gen.sv
design/id_pipe_reg.sv
design/id_stage.sv
bench/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_id_stage \
    -o tb_id_stage_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_id_stage_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
else
    exit 1
fi
